/* Makefile */
# Verilator build and run of the coprocessor testbench

TOP := cop_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f src.f
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -qx "Simulation passed" $(LOG) || (echo "Test failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* dv/cop_tb_ref.svh */
`ifndef COP_TB_REF_SVH
`define COP_TB_REF_SVH

// Expected host response for one request
typedef struct packed {
    word_t rd_data;
    logic  rd_wen;
    logic  exc;
} exp_t;

word_t       shadow [16];                 // Model of the crypto registers
logic [31:0] lcg_state = 32'ha20c_2bfa;

function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

function automatic word_t rand_word();
    lcg_state = lcg_next(lcg_state);
    return lcg_state ^ (lcg_state >> 15);   // Low LCG bits are weak
endfunction

function automatic word_t mk_instr(input logic [2:0] cls, input logic [3:0] sub,
                                   input logic [2:0] pw, input creg_idx_t crd,
                                   input creg_idx_t rs1, input logic [4:0] rs2);
    return {sub, pw, rs2, 1'b0, rs1, cls, 1'b0, crd, 7'b0001011};
endfunction

// xcr2gpr of one crypto register
function automatic word_t read_cr(input creg_idx_t idx);
    return mk_instr(CLS_MOVE, XCR2GPR, PW32, 4'd0, idx, 5'd0);
endfunction

// Kind 0 opcode, 1 class, 2 subclass, 3 pack width
function automatic word_t mk_illegal(input int kind, input word_t v);
    word_t op;
    op = mk_instr(CLS_PACKED, {1'b0, v[30:28]}, v[27:25] % 3'd5, v[10:7], v[18:15], v[24:20]);
    case (kind)
        0: op[6:0] = 7'b0001011 ^ {v[6:1], 1'b1};
        1: op[14:12] = 3'd2 + (v[13:11] % 3'd6);
        2: begin
            op[31:28] = {1'b1, v[30:28]};
            op[12]    = v[31];              // Packed or move
        end
        default: op[27:25] = 3'd5 + (v[27:25] % 3'd3);
    endcase
    return op;
endfunction

function automatic word_t lane_op(input logic [3:0] sub, input logic [2:0] pw,
                                  input word_t a, input word_t b, input logic [4:0] imm);
    int          lw;
    int          amt;
    logic [63:0] la;
    logic [63:0] lb;
    logic [63:0] lr;
    logic [63:0] mask;
    word_t       r;
    lw   = 32 >> pw;
    mask = (64'd1 << lw) - 64'd1;
    r    = '0;
    for (int i = 0; i < 32 / lw; i++) begin
        la  = {32'd0, a >> (i * lw)} & mask;
        lb  = {32'd0, b >> (i * lw)} & mask;
        amt = (sub >= 4'd5) ? int'(imm) % lw : int'(lb[4:0]) % lw;
        case (sub)
            PADD:         lr = la + lb;
            PSUB:         lr = la - lb;
            PSLL, PSLL_I: lr = la << amt;
            PSRL, PSRL_I: lr = la >> amt;
            default:      lr = (la >> amt) | (la << (lw - amt));
        endcase
        r = r | word_t'((lr & mask) << (i * lw));
    end
    return r;
endfunction

function automatic exp_t ref_exec(input word_t instr, input word_t gpr);
    exp_t       e;
    logic [2:0] cls;
    logic [3:0] sub;
    logic [2:0] pw;
    creg_idx_t  crd;
    word_t      a;
    word_t      b;
    cls = instr[14:12];
    sub = instr[31:28];
    pw  = instr[27:25];
    crd = instr[10:7];
    a   = shadow[instr[18:15]];
    b   = shadow[instr[23:20]];
    e   = '0;
    if (instr[6:0] != 7'b0001011 || cls > 3'd1) begin
        e.exc = 1'b1;
    end else if (cls == 3'd0) begin
        e.exc = (sub > 4'd7) || (pw > 3'd4) || !PW_EN_TB[pw];
    end else begin
        e.exc = (sub > 4'd3);   // Pack width unused by moves
    end
    if (e.exc) begin
        return e;               // No state change
    end
    if (cls == 3'd0) begin
        shadow[crd] = lane_op(sub, pw, a, b, instr[24:20]);
    end else begin
        case (sub)
            4'd0: begin
                e.rd_wen  = 1'b1;
                e.rd_data = a;
            end
            4'd1: shadow[crd] = gpr;
            4'd2: if (b != '0) shadow[crd] = a;
            default: if (b == '0) shadow[crd] = a;
        endcase
    end
    return e;
endfunction

`endif

/* dv/cop_tb.sv */
`timescale 1ns/1ps

module cop_tb;
    import cop_pkg::*;

    localparam logic [4:0] PW_EN_TB = 5'b11111;
    localparam int         TIMEOUT  = 20;   // Cycles per handshake phase

    `include "cop_tb_ref.svh"

    logic  g_clk = 1'b0;
    logic  rst_n;
    logic  req;
    word_t instr;
    word_t gpr;
    logic  ack;
    word_t rd_data;
    logic  rd_wen;
    logic  exc;

    int    errors   = 0;
    int    n_reqs   = 0;
    int    n_acks   = 0;
    int    rise_cyc = 0;
    int    fall_cyc = 0;
    logic  ack_q    = 1'b0;
    exp_t  held     = '0;
    exp_t  exp_q [$];

    always #2 g_clk = ~g_clk;

    cop_top #(
        .PW_EN (PW_EN_TB)
    ) u_dut (
        .g_clk_i   (g_clk),
        .rst_n_i   (rst_n),
        .req_i     (req),
        .instr_i   (instr),
        .gpr_i     (gpr),
        .ack_o     (ack),
        .rd_data_o (rd_data),
        .rd_wen_o  (rd_wen),
        .exc_o     (exc)
    );

    task automatic check_word(input string name, input word_t exp_v, input word_t act_v);
        if (exp_v !== act_v) begin
            errors++;
            $display("[FAIL] %0t %s expected %08h got %08h", $time, name, exp_v, act_v);
        end
    endtask

    task automatic check_bit(input string name, input logic exp_v, input logic act_v);
        if (exp_v !== act_v) begin
            errors++;
            $display("[FAIL] %0t %s expected %b got %b", $time, name, exp_v, act_v);
        end
    endtask

    task automatic check_latency(input string name, input int exp_v, input int act_v);
        if (exp_v != act_v) begin
            errors++;
            $display("[FAIL] %0t %s expected %0d cycles got %0d", $time, name, exp_v, act_v);
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timeout at %0t waiting for %s", $time, what);
        $display("Simulation failed");
        $finish;
    endtask

    // One full four-phase handshake where the host holds req for hold extra cycles
    task automatic run_op(input word_t op, input word_t gval, input int hold);
        int t;
        exp_q.push_back(ref_exec(op, gval));
        n_reqs++;
        @(posedge g_clk);
        req   <= 1'b1;
        instr <= op;
        gpr   <= gval;
        t = 0;
        @(negedge g_clk);
        while (!ack) begin
            t++;
            if (t > TIMEOUT) stop_on_timeout("ack_o to rise");
            @(negedge g_clk);
        end
        repeat (hold) @(posedge g_clk);
        @(posedge g_clk);
        req <= 1'b0;
        t = 0;
        @(negedge g_clk);
        while (ack) begin
            t++;
            if (t > TIMEOUT) stop_on_timeout("ack_o to fall");
            @(negedge g_clk);
        end
    endtask

    // Response checker sampled at the falling edge
    always @(negedge g_clk) begin
        exp_t e;
        if (rst_n) begin
            if (req && !ack) rise_cyc++;
            if (!req && ack) fall_cyc++;
            if (ack && !ack_q) begin
                n_acks++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Acknowledge at %0t with no request pending", $time);
                end else begin
                    e = exp_q.pop_front();
                    check_latency("ack_o rise", 3, rise_cyc);
                    check_bit("exc_o", e.exc, exc);
                    check_bit("rd_wen_o", e.rd_wen, rd_wen);
                    if (e.rd_wen) check_word("rd_data_o", e.rd_data, rd_data);
                    held = e;
                end
                rise_cyc = 0;
            end else if (ack && ack_q) begin
                // Held while host waits
                check_bit("exc_o", held.exc, exc);
                check_bit("rd_wen_o", held.rd_wen, rd_wen);
                if (held.rd_wen) check_word("rd_data_o", held.rd_data, rd_data);
            end
            if (!ack && ack_q) begin
                check_latency("ack_o fall", 1, fall_cyc);
                fall_cyc = 0;
            end
            ack_q = ack;
        end
    end

    initial begin
        word_t v;
        word_t op;
        rst_n = 1'b0;
        req   = 1'b0;
        instr = '0;
        gpr   = '0;
        for (int i = 0; i < 16; i++) shadow[i] = '0;
        repeat (5) @(posedge g_clk);
        rst_n <= 1'b1;

        // Load every register, then read each back
        for (int i = 0; i < 16; i++) begin
            run_op(mk_instr(CLS_MOVE, GPR2XCR, PW32, creg_idx_t'(i), 4'd0, 5'd0), rand_word(), 0);
        end
        for (int i = 0; i < 16; i++) run_op(read_cr(creg_idx_t'(i)), '0, 0);

        // Register-operand packed ops at every width
        for (int p = 0; p < 5; p++) begin
            for (int s = 0; s < 5; s++) begin
                for (int n = 0; n < 8; n++) begin
                    v = rand_word();
                    run_op(mk_instr(CLS_MOVE, GPR2XCR, PW32, v[3:0], 4'd0, 5'd0), rand_word(), 0);
                    run_op(mk_instr(CLS_PACKED, 4'(s), 3'(p), v[14:11], v[18:15],
                                    {1'b0, v[22:19]}), '0, int'(v[24:23]));
                    run_op(read_cr(v[14:11]), '0, 0);
                end
            end
        end

        // Immediate shifts over all amounts
        for (int p = 0; p < 5; p++) begin
            for (int a = 0; a < 32; a++) begin
                for (int s = 5; s < 8; s++) begin
                    v = rand_word();
                    run_op(mk_instr(CLS_PACKED, 4'(s), 3'(p), v[3:0], v[7:4], 5'(a)), '0, 0);
                    run_op(read_cr(v[3:0]), '0, 0);
                end
            end
        end

        // cmov with a zero operand in r14 and a nonzero one in r15
        for (int n = 0; n < 16; n++) begin
            v = rand_word();
            run_op(mk_instr(CLS_MOVE, GPR2XCR, PW32, 4'd14, 4'd0, 5'd0), '0, 0);
            run_op(mk_instr(CLS_MOVE, GPR2XCR, PW32, 4'd15, 4'd0, 5'd0), v | 32'd1, 0);
            run_op(mk_instr(CLS_MOVE, n[0] ? CMOV_F : CMOV_T, PW32, {1'b0, v[10:8]},
                            {1'b0, v[13:11]}, n[1] ? 5'd15 : 5'd14), '0, 0);
            run_op(read_cr({1'b0, v[10:8]}), '0, 0);
        end

        // Illegal encodings must leave crd untouched
        for (int k = 0; k < 4; k++) begin
            for (int n = 0; n < 8; n++) begin
                op = mk_illegal(k, rand_word());
                run_op(op, rand_word(), n % 3);
                run_op(read_cr(op[10:7]), '0, 0);
            end
        end

        repeat (3) @(posedge g_clk);
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d acknowledges never arrived", exp_q.size());
        end
        $display("Requests %0d, acknowledges %0d, errors %0d", n_reqs, n_acks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* hdl/cop_dec_if.sv */
`timescale 1ns/1ps

interface cop_dec_if;
    import cop_pkg::*;

    logic       valid;      // Single-cycle pulse per accepted request
    cop_class_e cls;
    logic [3:0] sub;        // Meaning depends on cls
    cop_pw_e    pw;
    creg_idx_t  crd;
    word_t      crs1_val;
    word_t      crs2_val;
    shamt_t     imm;
    word_t      gpr_val;    // GPR operand from the host
    logic       exc;

    modport dec (
        output valid, cls, sub, pw, crd,
        output crs1_val, crs2_val, imm, gpr_val, exc
    );

    modport exe (
        input valid, cls, sub, pw, crd,
        input crs1_val, crs2_val, imm, gpr_val, exc
    );

endinterface

/* hdl/cop_idecode.sv */
`timescale 1ns/1ps

module cop_idecode #(
    parameter logic [4:0] PW_EN = 5'b11111   // Bit 0 enables 32-bit lanes
) (
    input  logic               g_clk_i,
    input  logic               rst_n_i,
    input  logic               req_i,
    input  cop_pkg::word_t     instr_i,
    input  cop_pkg::word_t     gpr_i,
    input  logic               ack_i,
    output cop_pkg::creg_idx_t rs1_addr_o,
    output cop_pkg::creg_idx_t rs2_addr_o,
    input  cop_pkg::word_t     rs1_data_i,
    input  cop_pkg::word_t     rs2_data_i,
    cop_dec_if.dec             dec
);
    import cop_pkg::*;

    logic [6:0] opc;
    cop_class_e cls;
    logic [3:0] sub;
    cop_pw_e    pw;
    logic       bad_opc;
    logic       bad_cls;
    logic       bad_sub;
    logic       bad_pw;
    logic       exc;
    logic       busy;
    logic       ack_q;
    logic       accept;
    logic       ack_fall;

    assign opc = instr_i[OPC_MSB:OPC_LSB];
    assign cls = cop_class_e'(instr_i[CLS_MSB:CLS_LSB]);
    assign sub = instr_i[SUB_MSB:SUB_LSB];
    assign pw  = cop_pw_e'(instr_i[PW_MSB:PW_LSB]);

    // Operand reads go straight to the register file
    assign rs1_addr_o = instr_i[CRS1_MSB:CRS1_LSB];
    assign rs2_addr_o = instr_i[CRS2_MSB:CRS2_LSB];

    assign bad_opc = (opc != COP_OPCODE);

    always_comb begin
        bad_cls = 1'b0;
        bad_sub = 1'b0;
        bad_pw  = 1'b0;
        case (cls)
            CLS_PACKED: begin
                bad_sub = (sub > PROT_I);
                // Codes above PW2 have no enable bit
                bad_pw  = (pw > PW2) ? 1'b1 : !PW_EN[pw];
            end
            CLS_MOVE: bad_sub = (sub > CMOV_F);   // Pack width ignored
            default:  bad_cls = 1'b1;
        endcase
    end

    assign exc = bad_opc | bad_cls | bad_sub | bad_pw;

    assign accept   = req_i && !busy;
    assign ack_fall = ack_q && !ack_i;   // End of the four-phase handshake

    always_ff @(posedge g_clk_i) begin
        if (!rst_n_i) begin
            busy      <= 1'b0;
            ack_q     <= 1'b0;
            dec.valid <= 1'b0;
            dec.exc   <= 1'b0;
        end else begin
            ack_q     <= ack_i;
            dec.valid <= accept;
            if (accept) begin
                busy    <= 1'b1;
                dec.exc <= exc;
            end else if (ack_fall) begin
                busy    <= 1'b0;
            end
        end
    end

    // Decoded payload with its operands
    always_ff @(posedge g_clk_i) begin
        if (accept) begin
            dec.cls      <= cls;
            dec.sub      <= sub;
            dec.pw       <= pw;
            dec.crd      <= instr_i[CRD_MSB:CRD_LSB];
            dec.imm      <= instr_i[IMM_MSB:IMM_LSB];
            dec.crs1_val <= rs1_data_i;
            dec.crs2_val <= rs2_data_i;
            dec.gpr_val  <= gpr_i;
        end
    end

    // Execute, result and host round trip leave a gap of several cycles
    a_one_decode: assert property (@(posedge g_clk_i) disable iff (!rst_n_i)
        dec.valid |=> !dec.valid ##1 !dec.valid ##1 !dec.valid ##1 !dec.valid);

endmodule

/* hdl/cop_palu.sv */
`timescale 1ns/1ps

module cop_palu (
    input  logic   g_clk_i,
    input  logic   rst_n_i,
    cop_dec_if.exe dec,
    cop_res_if.exe res
);
    import cop_pkg::*;

    cop_psub_e        op;
    cop_msub_e        msub;
    logic [4:0][31:0] pw_res;   // One packed result per lane width
    word_t            pk_res;
    logic             cr_wen;
    logic             rd_wen;
    word_t            cr_data;

    assign op   = cop_psub_e'(dec.sub);
    assign msub = cop_msub_e'(dec.sub);

    for (genvar k = 0; k < 5; k++) begin : g_pw
        localparam int LW = 32 >> k;
        localparam int SW = $clog2(LW);

        for (genvar j = 0; j < 32 / LW; j++) begin : g_lane
            logic [LW-1:0]   la;
            logic [LW-1:0]   lb;
            logic [LW-1:0]   lr;
            logic [SW-1:0]   amt;     // Shift amount modulo lane width
            logic [2*LW-1:0] rot;

            always_comb begin
                la  = dec.crs1_val[j*LW +: LW];
                lb  = dec.crs2_val[j*LW +: LW];
                amt = (op >= PSLL_I) ? dec.imm[SW-1:0] : lb[SW-1:0];
                rot = {la, la} >> amt;   // Rotate right
                case (op)
                    PADD:         lr = la + lb;
                    PSUB:         lr = la - lb;
                    PSLL, PSLL_I: lr = la << amt;
                    PSRL, PSRL_I: lr = la >> amt;
                    PROT, PROT_I: lr = rot[LW-1:0];
                    default:      lr = '0;
                endcase
            end

            assign pw_res[k][j*LW +: LW] = lr;
        end
    end

    assign pk_res = (dec.pw <= PW2) ? pw_res[dec.pw] : '0;

    always_comb begin
        cr_wen  = 1'b0;
        rd_wen  = 1'b0;
        cr_data = pk_res;
        case (dec.cls)
            CLS_PACKED: cr_wen = 1'b1;
            CLS_MOVE: begin
                case (msub)
                    XCR2GPR: rd_wen = 1'b1;
                    GPR2XCR: begin
                        cr_wen  = 1'b1;
                        cr_data = dec.gpr_val;
                    end
                    CMOV_T: begin
                        cr_wen  = |dec.crs2_val;
                        cr_data = dec.crs1_val;
                    end
                    CMOV_F: begin
                        cr_wen  = ~|dec.crs2_val;
                        cr_data = dec.crs1_val;
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
        if (dec.exc) begin   // Illegal instructions have no side effects
            cr_wen = 1'b0;
            rd_wen = 1'b0;
        end
    end

    always_ff @(posedge g_clk_i) begin
        if (!rst_n_i) begin
            res.valid  <= 1'b0;
            res.cr_wen <= 1'b0;
            res.rd_wen <= 1'b0;
            res.exc    <= 1'b0;
        end else begin
            res.valid  <= dec.valid;
            res.cr_wen <= dec.valid && cr_wen;
            res.rd_wen <= dec.valid && rd_wen;
            res.exc    <= dec.valid && dec.exc;
        end
    end

    always_ff @(posedge g_clk_i) begin
        if (dec.valid) begin
            res.crd     <= dec.crd;
            res.cr_data <= cr_data;
            res.rd_data <= dec.crs1_val;   // Only xcr2gpr returns data
        end
    end

    // Only legal operations reach the lane logic without an exception
    a_legal_exec: assert property (@(posedge g_clk_i) disable iff (!rst_n_i)
        dec.valid && !dec.exc |->
            (dec.cls == CLS_PACKED && dec.sub <= PROT_I && dec.pw <= PW2) ||
            (dec.cls == CLS_MOVE && dec.sub <= CMOV_F));

endmodule

/* hdl/cop_pkg.sv */
package cop_pkg;

    // Custom-0 major opcode
    localparam logic [6:0] COP_OPCODE = 7'b0001011;

    localparam int NUM_CREGS = 16;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  creg_idx_t;
    typedef logic [4:0]  shamt_t;   // Immediate shift amount

    // Instruction fields of the 32-bit encoding
    localparam int OPC_LSB  = 0;
    localparam int OPC_MSB  = 6;
    localparam int CRD_LSB  = 7;
    localparam int CRD_MSB  = 10;
    localparam int CLS_LSB  = 12;
    localparam int CLS_MSB  = 14;
    localparam int CRS1_LSB = 15;
    localparam int CRS1_MSB = 18;
    localparam int CRS2_LSB = 20;
    localparam int CRS2_MSB = 23;
    localparam int IMM_LSB  = 20;
    localparam int IMM_MSB  = 24;   // Overlaps crs2 for the immediate shifts
    localparam int PW_LSB   = 25;
    localparam int PW_MSB   = 27;
    localparam int SUB_LSB  = 28;
    localparam int SUB_MSB  = 31;

    // Only packed arithmetic and move are executed
    typedef enum logic [2:0] {
        CLS_PACKED    = 3'd0,
        CLS_MOVE      = 3'd1,
        CLS_LOADSTORE = 3'd2,
        CLS_RANDOM    = 3'd3,
        CLS_MP        = 3'd4,
        CLS_TWIDDLE   = 3'd5,
        CLS_BITWISE   = 3'd6
    } cop_class_e;

    typedef enum logic [3:0] {
        PADD   = 4'd0,
        PSUB   = 4'd1,
        PSLL   = 4'd2,
        PSRL   = 4'd3,
        PROT   = 4'd4,
        PSLL_I = 4'd5,
        PSRL_I = 4'd6,
        PROT_I = 4'd7
    } cop_psub_e;

    typedef enum logic [3:0] {
        XCR2GPR = 4'd0,
        GPR2XCR = 4'd1,
        CMOV_T  = 4'd2,
        CMOV_F  = 4'd3
    } cop_msub_e;

    // Lane width is 32 >> code
    typedef enum logic [2:0] {
        PW32 = 3'd0,
        PW16 = 3'd1,
        PW8  = 3'd2,
        PW4  = 3'd3,
        PW2  = 3'd4
    } cop_pw_e;

endpackage

/* hdl/cop_regfile.sv */
`timescale 1ns/1ps

module cop_regfile (
    input  logic               g_clk_i,
    input  logic               rst_n_i,
    input  cop_pkg::creg_idx_t rs1_addr_i,
    input  cop_pkg::creg_idx_t rs2_addr_i,
    output cop_pkg::word_t     rs1_data_o,
    output cop_pkg::word_t     rs2_data_o,
    input  logic               wen_i,
    input  cop_pkg::creg_idx_t waddr_i,
    input  cop_pkg::word_t     wdata_i
);
    import cop_pkg::*;

    word_t regs [NUM_CREGS];

    // Asynchronous read ports
    assign rs1_data_o = regs[rs1_addr_i];
    assign rs2_data_o = regs[rs2_addr_i];

    always_ff @(posedge g_clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_CREGS; i++) begin
                regs[i] <= '0;   // Crypto state starts clean
            end
        end else if (wen_i) begin
            regs[waddr_i] <= wdata_i;
        end
    end

endmodule

/* hdl/cop_res_if.sv */
`timescale 1ns/1ps

interface cop_res_if;
    import cop_pkg::*;

    logic      valid;       // Single-cycle pulse
    creg_idx_t crd;
    logic      cr_wen;      // Crypto register write
    word_t     cr_data;
    logic      rd_wen;      // Result goes back to the host GPR
    word_t     rd_data;
    logic      exc;

    modport exe (
        output valid, crd, cr_wen, cr_data, rd_wen, rd_data, exc
    );

    modport res (
        input valid, crd, cr_wen, cr_data, rd_wen, rd_data, exc
    );

endinterface

/* hdl/cop_result.sv */
`timescale 1ns/1ps

module cop_result (
    input  logic               g_clk_i,
    input  logic               rst_n_i,
    input  logic               req_i,
    cop_res_if.res             res,
    output logic               wen_o,
    output cop_pkg::creg_idx_t waddr_o,
    output cop_pkg::word_t     wdata_o,
    output logic               ack_o,
    output cop_pkg::word_t     rd_data_o,
    output logic               rd_wen_o,
    output logic               exc_o
);

    // Register file write lands on the same edge that raises ack_o
    assign wen_o   = res.valid && res.cr_wen;
    assign waddr_o = res.crd;
    assign wdata_o = res.cr_data;

    always_ff @(posedge g_clk_i) begin
        if (!rst_n_i) begin
            ack_o    <= 1'b0;
            rd_wen_o <= 1'b0;
            exc_o    <= 1'b0;
        end else if (res.valid) begin
            ack_o    <= 1'b1;
            rd_wen_o <= res.rd_wen;
            exc_o    <= res.exc;
        end else if (ack_o && !req_i) begin
            // Host released the request
            ack_o    <= 1'b0;
            rd_wen_o <= 1'b0;
            exc_o    <= 1'b0;
        end
    end

    // Held for the host until the handshake closes
    always_ff @(posedge g_clk_i) begin
        if (res.valid) begin
            rd_data_o <= res.rd_data;
        end
    end

    // Request must still be pending when the acknowledge goes out
    a_ack_on_req: assert property (@(posedge g_clk_i) disable iff (!rst_n_i)
        $rose(ack_o) |-> $past(req_i));

endmodule

/* hdl/cop_top.sv */
`timescale 1ns/1ps

module cop_top #(
    parameter logic [4:0] PW_EN = 5'b11111   // Pack width enables with bit 0 for 32-bit lanes
) (
    input  logic           g_clk_i,
    input  logic           rst_n_i,
    input  logic           req_i,
    input  cop_pkg::word_t instr_i,
    input  cop_pkg::word_t gpr_i,
    output logic           ack_o,
    output cop_pkg::word_t rd_data_o,
    output logic           rd_wen_o,
    output logic           exc_o
);
    import cop_pkg::*;

    creg_idx_t rs1_addr;
    creg_idx_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    logic      rf_wen;
    creg_idx_t rf_waddr;
    word_t     rf_wdata;

    cop_dec_if u_dec_if ();
    cop_res_if u_res_if ();

    cop_idecode #(
        .PW_EN (PW_EN)
    ) u_idecode (
        .g_clk_i    (g_clk_i),
        .rst_n_i    (rst_n_i),
        .req_i      (req_i),
        .instr_i    (instr_i),
        .gpr_i      (gpr_i),
        .ack_i      (ack_o),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .dec        (u_dec_if.dec)
    );

    cop_regfile u_regfile (
        .g_clk_i    (g_clk_i),
        .rst_n_i    (rst_n_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wen_i      (rf_wen),
        .waddr_i    (rf_waddr),
        .wdata_i    (rf_wdata)
    );

    cop_palu u_palu (
        .g_clk_i (g_clk_i),
        .rst_n_i (rst_n_i),
        .dec     (u_dec_if.exe),
        .res     (u_res_if.exe)
    );

    cop_result u_result (
        .g_clk_i   (g_clk_i),
        .rst_n_i   (rst_n_i),
        .req_i     (req_i),
        .res       (u_res_if.res),
        .wen_o     (rf_wen),
        .waddr_o   (rf_waddr),
        .wdata_o   (rf_wdata),
        .ack_o     (ack_o),
        .rd_data_o (rd_data_o),
        .rd_wen_o  (rd_wen_o),
        .exc_o     (exc_o)
    );

endmodule

/* src.f */
hdl/cop_pkg.sv
hdl/cop_dec_if.sv
hdl/cop_res_if.sv
hdl/cop_idecode.sv
hdl/cop_regfile.sv
hdl/cop_palu.sv
hdl/cop_result.sv
hdl/cop_top.sv
+incdir+dv
dv/cop_tb.sv
